// File: rtl/hazard_defines.svh
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Register file has sixteen entries
`define REG_ADDR_W 4

// Width of operands and results on the execute path
`define DATA_W 32

// R15 holds the program counter
// It comes from the fetch path and is never forwarded
`define PC_REG 15

`endif

// File: rtl/hazard_pkg.sv
`default_nettype none

`include "hazard_defines.svh"

package hazardPkg;

  // Register number as carried down the pipeline
  typedef logic [`REG_ADDR_W-1:0] regAddrT;

  // Operand or result word
  typedef logic [`DATA_W-1:0] dataT;

  // Source of an execute-stage operand
  // Code 2'b11 is left unused
  typedef enum logic [1:0] {
    fwdNone = 2'b00,  // Register file read
    fwdW    = 2'b01,  // Writeback result
    fwdM    = 2'b10   // Memory-stage ALU result
  } fwdSelT;

endpackage

`default_nettype wire

// File: rtl/stageTracker.sv
`timescale 1ns/1ns
`default_nettype none

module stageTracker (
  input  logic              clk,
  input  logic              rstN,
  // Decode-stage fields from the decoder
  input  logic              instrValidD,
  input  hazardPkg::regAddrT rs1D,
  input  hazardPkg::regAddrT rs2D,
  input  hazardPkg::regAddrT rdD,
  input  logic              regWriteD,
  input  logic              memToRegD,
  // Pipeline control from the hazard unit
  input  logic              stallD,
  input  logic              stallE,
  input  logic              stallM,
  input  logic              stallW,
  input  logic              flushE,
  input  logic              flushM,
  input  logic              flushW,
  // Tracked stage contents
  output logic              validE,
  output logic              validM,
  output logic              validW,
  output hazardPkg::regAddrT rs1E,
  output hazardPkg::regAddrT rs2E,
  output hazardPkg::regAddrT rdE,
  output hazardPkg::regAddrT rdM,
  output hazardPkg::regAddrT rdW,
  output logic              regWriteE,
  output logic              regWriteM,
  output logic              regWriteW,
  output logic              memToRegE
);

  // Next valid bit of each stage when that stage is allowed to advance
  logic nextValidE;
  logic nextValidM;
  logic nextValidW;

  // A stalled upstream stage hands on a bubble
  // A flush turns the incoming slot into a bubble too
  assign nextValidE = instrValidD & ~stallD & ~flushE;
  assign nextValidM = validE & ~stallE & ~flushM;
  // In writeback the stall wins over the flush
  // The flush there only kills the register-file write outside this block
  assign nextValidW = validM & ~stallM & ~flushW;

  // Decode to execute, control part
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      validE    <= 1'b0;
      regWriteE <= 1'b0;
      memToRegE <= 1'b0;
    end
    else if (!stallE)
    begin
      validE    <= nextValidE;
      // Flags are cleared in bubbles
      regWriteE <= regWriteD & nextValidE;
      memToRegE <= memToRegD & nextValidE;
    end
  end

  // Decode to execute, register numbers
  always_ff @(posedge clk)
  begin
    if (!stallE)
    begin
      rs1E <= rs1D;
      rs2E <= rs2D;
      rdE  <= rdD;
    end
  end

  // Execute to memory
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      validM    <= 1'b0;
      regWriteM <= 1'b0;
    end
    else if (!stallM)
    begin
      validM    <= nextValidM;
      regWriteM <= regWriteE & nextValidM;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stallM)
      rdM <= rdE;
  end

  // Memory to writeback
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      validW    <= 1'b0;
      regWriteW <= 1'b0;
    end
    else if (!stallW)
    begin
      validW    <= nextValidW;
      regWriteW <= regWriteM & nextValidW;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stallW)
      rdW <= rdM;
  end

  // Stall and flush on one stage would leave its content ambiguous
  // Writeback is exempt since a memory-system stall raises both there
  assert property (@(posedge clk) disable iff (!rstN) !(stallE && flushE))
    else $error("execute stage stalled and flushed together");
  assert property (@(posedge clk) disable iff (!rstN) !(stallM && flushM))
    else $error("memory stage stalled and flushed together");

endmodule

`default_nettype wire

// File: rtl/regMatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "hazard_defines.svh"

module regMatch (
  input  hazardPkg::regAddrT rs1D,
  input  hazardPkg::regAddrT rs2D,
  input  logic              instrValidD,
  input  logic              validE,
  input  logic              validM,
  input  logic              validW,
  input  hazardPkg::regAddrT rs1E,
  input  hazardPkg::regAddrT rs2E,
  input  hazardPkg::regAddrT rdE,
  input  hazardPkg::regAddrT rdM,
  input  hazardPkg::regAddrT rdW,
  // Execute sources against memory and writeback destinations
  output logic              match1EM,
  output logic              match1EW,
  output logic              match2EM,
  output logic              match2EW,
  // Decode sources against the execute destination
  output logic              match1DE,
  output logic              match2DE
);

  localparam hazardPkg::regAddrT PcReg = `PC_REG;

  // Sources that may take a forwarded value
  // PC reads come from the fetch path
  logic fwdOk1E;
  logic fwdOk2E;
  logic fwdOk1D;
  logic fwdOk2D;

  assign fwdOk1E = validE & (rs1E != PcReg);
  assign fwdOk2E = validE & (rs2E != PcReg);
  assign fwdOk1D = instrValidD & (rs1D != PcReg);
  assign fwdOk2D = instrValidD & (rs2D != PcReg);

  assign match1EM = fwdOk1E & validM & (rs1E == rdM);
  assign match1EW = fwdOk1E & validW & (rs1E == rdW);
  assign match2EM = fwdOk2E & validM & (rs2E == rdM);
  assign match2EW = fwdOk2E & validW & (rs2E == rdW);

  // Load-use candidates, only one stage apart
  assign match1DE = fwdOk1D & validE & (rs1D == rdE);
  assign match2DE = fwdOk2D & validE & (rs2D == rdE);

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
  input  logic              clk,
  input  logic              rstN,
  // Register matches
  input  logic              match1EM,
  input  logic              match1EW,
  input  logic              match2EM,
  input  logic              match2EW,
  input  logic              match1DE,
  input  logic              match2DE,
  // Stage flags
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              memToRegE,
  // Control-flow events
  input  logic              branchTakenE,
  input  logic              pcWrPendingF,
  input  logic              pcSrcW,
  // Memory system
  input  logic              dStall,
  input  logic              iStall,
  output hazardPkg::fwdSelT forwardAE,
  output hazardPkg::fwdSelT forwardBE,
  output logic              stallF,
  output logic              stallD,
  output logic              stallE,
  output logic              stallM,
  output logic              stallW,
  output logic              flushD,
  output logic              flushE,
  output logic              flushM,
  output logic              flushW
);

  logic memStall;
  logic ldStallD;

  // Memory stage is the younger result so it wins
  function automatic hazardPkg::fwdSelT selectFwd(input logic hitM, input logic hitW);
    if (hitM)
      return hazardPkg::fwdM;
    else if (hitW)
      return hazardPkg::fwdW;
    else
      return hazardPkg::fwdNone;
  endfunction

  // Only stages that write a register may forward
  assign forwardAE = selectFwd(match1EM & regWriteM, match1EW & regWriteW);
  assign forwardBE = selectFwd(match2EM & regWriteM, match2EW & regWriteW);

  // Either cache holding up the pipeline
  assign memStall = dStall | iStall;

  // Load result not ready until memory stage ends
  // Hold decode one cycle and send a bubble into execute
  assign ldStallD = (match1DE | match2DE) & memToRegE;

  // Fetch also waits while a PC write is in flight
  assign stallF = ldStallD | pcWrPendingF | memStall;
  assign stallD = ldStallD | memStall;
  assign stallE = memStall;
  assign stallM = memStall;
  assign stallW = memStall;

  // Wrong-path fetches after a branch or a PC write get squashed
  assign flushD = pcWrPendingF | pcSrcW | branchTakenE | iStall;
  assign flushE = ldStallD | branchTakenE;
  // No memory-stage flush source without exceptions
  assign flushM = 1'b0;
  assign flushW = memStall;

  // After a load-use stall the load sits behind a bubble
  // So the stalled source can't be served from memory next cycle
  assert property (@(posedge clk) disable iff (!rstN)
    match1DE && memToRegE && !memStall |=> forwardAE != hazardPkg::fwdM)
    else $error("source A forwarded from memory right after load-use");
  assert property (@(posedge clk) disable iff (!rstN)
    match2DE && memToRegE && !memStall |=> forwardBE != hazardPkg::fwdM)
    else $error("source B forwarded from memory right after load-use");

endmodule

`default_nettype wire

// File: rtl/operandForward.sv
`timescale 1ns/1ns
`default_nettype none

module operandForward (
  input  hazardPkg::fwdSelT forwardAE,
  input  hazardPkg::fwdSelT forwardBE,
  // Register-file reads for the execute instruction
  input  hazardPkg::dataT   rfData1E,
  input  hazardPkg::dataT   rfData2E,
  // Results further down the pipe
  input  hazardPkg::dataT   aluResultM,
  input  hazardPkg::dataT   resultW,
  output hazardPkg::dataT   srcAE,
  output hazardPkg::dataT   srcBE
);

  // Three-way operand mux shared by both sources
  function automatic hazardPkg::dataT pickOperand(
    input hazardPkg::fwdSelT sel,
    input hazardPkg::dataT   rfData,
    input hazardPkg::dataT   memData,
    input hazardPkg::dataT   wbData
  );
    case (sel)
      hazardPkg::fwdM: return memData;
      hazardPkg::fwdW: return wbData;
      // fwdNone, also the unused code
      default:         return rfData;
    endcase
  endfunction

  assign srcAE = pickOperand(forwardAE, rfData1E, aluResultM, resultW);
  assign srcBE = pickOperand(forwardBE, rfData2E, aluResultM, resultW);

endmodule

`default_nettype wire

// File: rtl/hazardTop.sv
`timescale 1ns/1ns
`default_nettype none

module hazardTop (
  input  logic              clk,
  input  logic              rstN,
  // Decode-stage fields, held by the source while stallF is high
  input  logic              instrValidD,
  input  hazardPkg::regAddrT rs1D,
  input  hazardPkg::regAddrT rs2D,
  input  hazardPkg::regAddrT rdD,
  input  logic              regWriteD,
  input  logic              memToRegD,
  // Control-flow events
  input  logic              branchTakenE,
  input  logic              pcWrPendingF,
  input  logic              pcSrcW,
  // Memory-system stalls
  input  logic              dStall,
  input  logic              iStall,
  // Operand sources
  input  hazardPkg::dataT   rfData1E,
  input  hazardPkg::dataT   rfData2E,
  input  hazardPkg::dataT   aluResultM,
  input  hazardPkg::dataT   resultW,
  output logic              stallF,
  output logic              stallD,
  output logic              stallE,
  output logic              stallM,
  output logic              stallW,
  output logic              flushD,
  output logic              flushE,
  output logic              flushM,
  output logic              flushW,
  output hazardPkg::fwdSelT forwardAE,
  output hazardPkg::fwdSelT forwardBE,
  output hazardPkg::dataT   srcAE,
  output hazardPkg::dataT   srcBE
);

  // Tracked stage contents
  logic               validE;
  logic               validM;
  logic               validW;
  hazardPkg::regAddrT rs1E;
  hazardPkg::regAddrT rs2E;
  hazardPkg::regAddrT rdE;
  hazardPkg::regAddrT rdM;
  hazardPkg::regAddrT rdW;
  logic               regWriteE;
  logic               regWriteM;
  logic               regWriteW;
  logic               memToRegE;

  // Register matches
  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  logic match1DE;
  logic match2DE;

  stageTracker uTracker (
    .clk         (clk),
    .rstN        (rstN),
    .instrValidD (instrValidD),
    .rs1D        (rs1D),
    .rs2D        (rs2D),
    .rdD         (rdD),
    .regWriteD   (regWriteD),
    .memToRegD   (memToRegD),
    .stallD      (stallD),
    .stallE      (stallE),
    .stallM      (stallM),
    .stallW      (stallW),
    .flushE      (flushE),
    .flushM      (flushM),
    .flushW      (flushW),
    .validE      (validE),
    .validM      (validM),
    .validW      (validW),
    .rs1E        (rs1E),
    .rs2E        (rs2E),
    .rdE         (rdE),
    .rdM         (rdM),
    .rdW         (rdW),
    .regWriteE   (regWriteE),
    .regWriteM   (regWriteM),
    .regWriteW   (regWriteW),
    .memToRegE   (memToRegE)
  );

  regMatch uMatch (
    .rs1D        (rs1D),
    .rs2D        (rs2D),
    .instrValidD (instrValidD),
    .validE      (validE),
    .validM      (validM),
    .validW      (validW),
    .rs1E        (rs1E),
    .rs2E        (rs2E),
    .rdE         (rdE),
    .rdM         (rdM),
    .rdW         (rdW),
    .match1EM    (match1EM),
    .match1EW    (match1EW),
    .match2EM    (match2EM),
    .match2EW    (match2EW),
    .match1DE    (match1DE),
    .match2DE    (match2DE)
  );

  hazardUnit uHazard (
    .clk          (clk),
    .rstN         (rstN),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .match1DE     (match1DE),
    .match2DE     (match2DE),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .memToRegE    (memToRegE),
    .branchTakenE (branchTakenE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .dStall       (dStall),
    .iStall       (iStall),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallF       (stallF),
    .stallD       (stallD),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushD       (flushD),
    .flushE       (flushE),
    .flushM       (flushM),
    .flushW       (flushW)
  );

  operandForward uForward (
    .forwardAE  (forwardAE),
    .forwardBE  (forwardBE),
    .rfData1E   (rfData1E),
    .rfData2E   (rfData2E),
    .aluResultM (aluResultM),
    .resultW    (resultW),
    .srcAE      (srcAE),
    .srcBE      (srcBE)
  );

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock with a 4 ns period
module clockGen (
  output logic clk
);

  localparam int HalfPeriod = 2;

  initial
  begin
    clk = 1'b0;
    forever
      #HalfPeriod clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tb/hazardTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "hazard_defines.svh"

module hazardTb;

  localparam int NumCycles   = 2000;
  localparam int CycleLimit  = 2 * NumCycles;
  localparam int ResetCycles = 5;
  localparam hazardPkg::regAddrT PcReg = `PC_REG;

  logic clk;
  logic rstN;

  // DUT inputs
  logic               instrValidD;
  hazardPkg::regAddrT rs1D;
  hazardPkg::regAddrT rs2D;
  hazardPkg::regAddrT rdD;
  logic               regWriteD;
  logic               memToRegD;
  logic               branchTakenE;
  logic               pcWrPendingF;
  logic               pcSrcW;
  logic               dStall;
  logic               iStall;
  hazardPkg::dataT    rfData1E;
  hazardPkg::dataT    rfData2E;
  hazardPkg::dataT    aluResultM;
  hazardPkg::dataT    resultW;

  // DUT outputs
  logic stallF;
  logic stallD;
  logic stallE;
  logic stallM;
  logic stallW;
  logic flushD;
  logic flushE;
  logic flushM;
  logic flushW;
  hazardPkg::fwdSelT forwardAE;
  hazardPkg::fwdSelT forwardBE;
  hazardPkg::dataT   srcAE;
  hazardPkg::dataT   srcBE;

  // Reference pipeline, state after the coming edge once advanced
  logic               mValidE = 1'b0;
  logic               mValidM = 1'b0;
  logic               mValidW = 1'b0;
  hazardPkg::regAddrT mRs1E = '0;
  hazardPkg::regAddrT mRs2E = '0;
  hazardPkg::regAddrT mRdE = '0;
  hazardPkg::regAddrT mRdM = '0;
  hazardPkg::regAddrT mRdW = '0;
  logic               mRegWriteE = 1'b0;
  logic               mRegWriteM = 1'b0;
  logic               mRegWriteW = 1'b0;
  logic               mMemToRegE = 1'b0;

  // Expected outputs for the current cycle
  logic expLoadUse;
  logic expStallF;
  logic expStallD;
  logic expStallE;
  logic expStallM;
  logic expStallW;
  logic expFlushD;
  logic expFlushE;
  logic expFlushM;
  logic expFlushW;
  hazardPkg::fwdSelT expFwdA;
  hazardPkg::fwdSelT expFwdB;
  hazardPkg::dataT   expSrcA;
  hazardPkg::dataT   expSrcB;

  logic checking = 1'b0;
  logic holdDecode = 1'b0;
  int   stallLeft = 0;
  int   cycleCount = 0;

  // Event tallies
  int loadUseCount = 0;
  int fwdMCount = 0;
  int fwdWCount = 0;
  int memStallCount = 0;
  int branchCount = 0;

  clockGen clockGen0 (
    .clk (clk)
  );

  hazardTop dut0 (
    .clk          (clk),
    .rstN         (rstN),
    .instrValidD  (instrValidD),
    .rs1D         (rs1D),
    .rs2D         (rs2D),
    .rdD          (rdD),
    .regWriteD    (regWriteD),
    .memToRegD    (memToRegD),
    .branchTakenE (branchTakenE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .dStall       (dStall),
    .iStall       (iStall),
    .rfData1E     (rfData1E),
    .rfData2E     (rfData2E),
    .aluResultM   (aluResultM),
    .resultW      (resultW),
    .stallF       (stallF),
    .stallD       (stallD),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushD       (flushD),
    .flushE       (flushE),
    .flushM       (flushM),
    .flushW       (flushW),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .srcAE        (srcAE),
    .srcBE        (srcBE)
  );

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      failRun($sformatf("FAIL time=%0t signal=%s expected=%b actual=%b",
                        $time, name, expected, actual));
  endtask

  task automatic checkFwd(input string name, input hazardPkg::fwdSelT expected,
                          input hazardPkg::fwdSelT actual);
    if (actual !== expected)
      failRun($sformatf("FAIL time=%0t signal=%s expected=%b actual=%b",
                        $time, name, expected, actual));
  endtask

  task automatic checkData(input string name, input hazardPkg::dataT expected,
                           input hazardPkg::dataT actual);
    if (actual !== expected)
      failRun($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                        $time, name, expected, actual));
  endtask

  // Decode source waiting on a load that sits in execute
  // PC reads never count
  function automatic logic loadUseAhead(input logic valid, input hazardPkg::regAddrT src1,
                                        input hazardPkg::regAddrT src2);
    logic hit1;
    logic hit2;
    hit1 = (src1 != PcReg) && (src1 == mRdE);
    hit2 = (src2 != PcReg) && (src2 == mRdE);
    return valid && mValidE && mMemToRegE && (hit1 || hit2);
  endfunction

  function automatic hazardPkg::dataT chosenWord(input hazardPkg::fwdSelT sel,
                                                 input hazardPkg::dataT rfWord);
    if (sel == hazardPkg::fwdM)
      return aluResultM;
    if (sel == hazardPkg::fwdW)
      return resultW;
    return rfWord;
  endfunction

  task automatic computeExpected;
    logic hit1M;
    logic hit1W;
    logic hit2M;
    logic hit2W;
    logic memHold;
    // A source takes a result only from a valid stage that writes a register
    hit1M = mValidE && mValidM && mRegWriteM && (mRs1E != PcReg) && (mRs1E == mRdM);
    hit1W = mValidE && mValidW && mRegWriteW && (mRs1E != PcReg) && (mRs1E == mRdW);
    hit2M = mValidE && mValidM && mRegWriteM && (mRs2E != PcReg) && (mRs2E == mRdM);
    hit2W = mValidE && mValidW && mRegWriteW && (mRs2E != PcReg) && (mRs2E == mRdW);
    // Younger memory-stage result has priority
    expFwdA = hazardPkg::fwdNone;
    if (hit1M)
      expFwdA = hazardPkg::fwdM;
    else if (hit1W)
      expFwdA = hazardPkg::fwdW;
    expFwdB = hazardPkg::fwdNone;
    if (hit2M)
      expFwdB = hazardPkg::fwdM;
    else if (hit2W)
      expFwdB = hazardPkg::fwdW;
    expSrcA = chosenWord(expFwdA, rfData1E);
    expSrcB = chosenWord(expFwdB, rfData2E);
    expLoadUse = loadUseAhead(instrValidD, rs1D, rs2D);
    memHold = dStall || iStall;
    expStallF = expLoadUse || pcWrPendingF || memHold;
    expStallD = expLoadUse || memHold;
    expStallE = memHold;
    expStallM = memHold;
    expStallW = memHold;
    expFlushD = pcWrPendingF || pcSrcW || branchTakenE || iStall;
    expFlushE = expLoadUse || branchTakenE;
    expFlushM = 1'b0;
    expFlushW = memHold;
  endtask

  task automatic compareOutputs;
    checkBit("stallF", expStallF, stallF);
    checkBit("stallD", expStallD, stallD);
    checkBit("stallE", expStallE, stallE);
    checkBit("stallM", expStallM, stallM);
    checkBit("stallW", expStallW, stallW);
    checkBit("flushD", expFlushD, flushD);
    checkBit("flushE", expFlushE, flushE);
    checkBit("flushM", expFlushM, flushM);
    checkBit("flushW", expFlushW, flushW);
    checkFwd("forwardAE", expFwdA, forwardAE);
    checkFwd("forwardBE", expFwdB, forwardBE);
    checkData("srcAE", expSrcA, srcAE);
    checkData("srcBE", expSrcB, srcBE);
  endtask

  // Older stages first so each one reads the content before the edge
  task automatic advanceModel;
    if (!expStallW)
    begin
      mValidW    = mValidM && !expStallM && !expFlushW;
      mRdW       = mRdM;
      mRegWriteW = mRegWriteM && mValidW;
    end
    if (!expStallM)
    begin
      mValidM    = mValidE && !expStallE && !expFlushM;
      mRdM       = mRdE;
      mRegWriteM = mRegWriteE && mValidM;
    end
    if (!expStallE)
    begin
      mValidE    = instrValidD && !expStallD && !expFlushE;
      mRs1E      = rs1D;
      mRs2E      = rs2D;
      mRdE       = rdD;
      mRegWriteE = regWriteD && mValidE;
      mMemToRegE = memToRegD && mValidE;
    end
  endtask

  task automatic tallyEvents;
    if (expLoadUse)
      loadUseCount++;
    if (expFwdA == hazardPkg::fwdM || expFwdB == hazardPkg::fwdM)
      fwdMCount++;
    if (expFwdA == hazardPkg::fwdW || expFwdB == hazardPkg::fwdW)
      fwdWCount++;
    if (dStall || iStall)
      memStallCount++;
    if (branchTakenE)
      branchCount++;
  endtask

  // New random inputs for the next cycle
  // Memory stalls never start alongside a branch or a load-use hit
  task automatic driveStimulus;
    logic [31:0]        fieldBits;
    logic [31:0]        eventBits;
    logic               nValid;
    hazardPkg::regAddrT n1;
    hazardPkg::regAddrT n2;
    hazardPkg::regAddrT nd;
    logic               nWr;
    logic               nLoad;
    logic               branch;
    logic               stallStart;
    fieldBits = $urandom;
    eventBits = $urandom;
    if (holdDecode)
    begin
      nValid = instrValidD;
      n1     = rs1D;
      n2     = rs2D;
      nd     = rdD;
      nWr    = regWriteD;
      nLoad  = memToRegD;
    end
    else
    begin
      nValid = fieldBits[1:0] != 2'd0;
      n1     = fieldBits[7:4];
      n2     = fieldBits[11:8];
      nd     = fieldBits[15:12];
      nWr    = fieldBits[18:16] != 3'd0;
      nLoad  = nWr && (fieldBits[21:20] == 2'd0);
    end
    branch = (stallLeft == 0) && (eventBits[3:0] == 4'd0);
    stallStart = !branch && (stallLeft == 0) && !loadUseAhead(nValid, n1, n2)
                 && (eventBits[18:15] == 4'd0);
    instrValidD  <= nValid;
    rs1D         <= n1;
    rs2D         <= n2;
    rdD          <= nd;
    regWriteD    <= nWr;
    memToRegD    <= nLoad;
    branchTakenE <= branch;
    pcWrPendingF <= eventBits[8:4] == 5'd0;
    pcSrcW       <= eventBits[13:9] == 5'd0;
    if (stallLeft > 0)
      stallLeft = stallLeft - 1;
    else if (stallStart)
    begin
      // One to four cycles from data cache, instruction cache or both
      stallLeft = int'(eventBits[21:20]);
      dStall <= eventBits[23:22] != 2'd1;
      iStall <= (eventBits[23:22] == 2'd1) || (eventBits[23:22] == 2'd2);
    end
    else
    begin
      dStall <= 1'b0;
      iStall <= 1'b0;
    end
    rfData1E   <= $urandom;
    rfData2E   <= $urandom;
    aluResultM <= $urandom;
    resultW    <= $urandom;
  endtask

  // Outputs are settled mid-cycle
  always @(negedge clk)
  begin
    if (checking)
    begin
      computeExpected();
      compareOutputs();
      if (rstN)
      begin
        tallyEvents();
        advanceModel();
      end
      holdDecode = expStallF;
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > CycleLimit)
      failRun($sformatf("Timeout: the run did not finish within %0d cycles", CycleLimit));
  end

  initial
  begin
    void'($urandom(32'h5c3e));
    rstN         = 1'b0;
    instrValidD  = 1'b0;
    rs1D         = '0;
    rs2D         = '0;
    rdD          = '0;
    regWriteD    = 1'b0;
    memToRegD    = 1'b0;
    branchTakenE = 1'b0;
    pcWrPendingF = 1'b0;
    pcSrcW       = 1'b0;
    dStall       = 1'b0;
    iStall       = 1'b0;
    rfData1E     = '0;
    rfData2E     = '0;
    aluResultM   = '0;
    resultW      = '0;
    @(posedge clk);
    checking = 1'b1;
    repeat (ResetCycles - 1)
      @(posedge clk);
    rstN <= 1'b1;
    // Empty pipeline with quiet inputs raises no stall or flush
    @(negedge clk);
    checkBit("stallF", 1'b0, stallF);
    checkBit("stallD", 1'b0, stallD);
    checkBit("stallE", 1'b0, stallE);
    checkBit("stallM", 1'b0, stallM);
    checkBit("stallW", 1'b0, stallW);
    checkBit("flushD", 1'b0, flushD);
    checkBit("flushE", 1'b0, flushE);
    checkBit("flushM", 1'b0, flushM);
    checkBit("flushW", 1'b0, flushW);
    for (int i = 0; i < NumCycles; i++)
    begin
      @(posedge clk);
      driveStimulus();
    end
    repeat (6)
      @(posedge clk);
    @(negedge clk);
    // Stimulus must have reached each hazard kind
    if (loadUseCount == 0)
      failRun("The stimulus never produced a load-use stall");
    else if (fwdMCount == 0 || fwdWCount == 0)
      failRun("The stimulus never forwarded from both the memory and writeback stages");
    else if (memStallCount == 0)
      failRun("The stimulus never raised a memory-system stall");
    else if (branchCount == 0)
      failRun("The stimulus never raised a taken branch");
    else
    begin
      $display("Load-use %0d, fwd M %0d, fwd W %0d, mem stall %0d, branch %0d",
               loadUseCount, fwdMCount, fwdWCount, memStallCount, branchCount);
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/hazard_pkg.sv
rtl/stageTracker.sv
rtl/regMatch.sv
rtl/hazardUnit.sv
rtl/operandForward.sv
rtl/hazardTop.sv
tb/clockGen.sv
tb/hazardTb.sv

// File: Bender.yml
package:
  name: hazard_forwarding

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hazard_pkg.sv
      - rtl/stageTracker.sv
      - rtl/regMatch.sv
      - rtl/hazardUnit.sv
      - rtl/operandForward.sv
      - rtl/hazardTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/clockGen.sv
      - tb/hazardTb.sv
